// File: sim.f
+incdir+include
rtl/heapPkg.sv
rtl/heapBusIf.sv
rtl/heapAllocator.sv
rtl/arrayBank.sv
rtl/resultSelect.sv
rtl/heapMemory.sv
verification/heapMemoryTb.sv

// File: verification/heapMemoryTb.sv
// Array heap testbench
// Applies a table of commands back to back and checks every response,
// its latency and its error code against expected values

`timescale 1ns/1ps
`default_nettype none

`include "heap_defs.svh"

module heapMemoryTb;
  import heapPkg::*;

  localparam int ClockPeriod = 40;
  localparam int Latency     = 5;                 // Negedges from drive edge to done

  typedef struct packed {
    heapAction_t                 action;
    logic [`HEAP_ARRAY_BITS-1:0] array;
    logic [`HEAP_INDEX_BITS-1:0] index;
    logic [`HEAP_DATA_BITS-1:0]  data;
    logic [`HEAP_DATA_BITS-1:0]  expData;
    heapError_t                  expError;
  } stimRow_t;

  typedef struct packed {
    logic [`HEAP_DATA_BITS-1:0] data;
    heapError_t                 error;
    int                         doneCycle;
  } expectation_t;

  logic                        clock = 1'b0;
  logic                        resetN;
  logic                        start;
  heapAction_t                 action;
  logic [`HEAP_ARRAY_BITS-1:0] array;
  logic [`HEAP_INDEX_BITS-1:0] index;
  logic [`HEAP_DATA_BITS-1:0]  dataIn;
  logic                        done;
  logic [`HEAP_DATA_BITS-1:0]  dataOut;
  heapError_t                  error;

  stimRow_t                    rows [$];
  expectation_t                pending [$];
  logic [`HEAP_DATA_BITS-1:0]  model [$];       // Live words of the random array
  integer                      seed;
  int                          negCount = 0;
  int                          directedCount;
  int                          randomCount;
  logic                        tableReady = 1'b0;

  heapMemory dut_i (
    .clock   (clock),
    .resetN  (resetN),
    .start   (start),
    .action  (action),
    .array   (array),
    .index   (index),
    .dataIn  (dataIn),
    .done    (done),
    .dataOut (dataOut),
    .error   (error)
  );

  always #(ClockPeriod / 2) clock = ~clock;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "Stopped at first failure");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
      reportFailure($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                              $time, name, actual, expected));
  endtask

  task automatic addRow(input heapAction_t act, input logic [`HEAP_ARRAY_BITS-1:0] arr,
                        input logic [`HEAP_INDEX_BITS-1:0] idx,
                        input logic [`HEAP_DATA_BITS-1:0] d,
                        input logic [`HEAP_DATA_BITS-1:0] expData, input heapError_t expError);
    rows.push_back('{act, arr, idx, d, expData, expError});
  endtask

  function automatic logic [`HEAP_DATA_BITS-1:0] countModel(
      input logic [`HEAP_DATA_BITS-1:0] word, input logic below);
    logic [`HEAP_DATA_BITS-1:0] count;
    count = '0;
    foreach (model[i])
      if (below ? (model[i] < word) : (model[i] > word))
        count++;
    return count;
  endfunction

  task automatic buildTable();
    logic [31:0]                randomValue;
    logic [`HEAP_DATA_BITS-1:0] word;
    addRow(actSize, 0, 0, 0, 0, errNotAllocated);
    addRow(actClear, 0, 0, 0, 0, errNone);
    for (int i = 0; i < `HEAP_ARRAYS; i++)
      addRow(actAlloc, 0, 0, 0, i, errNone);
    addRow(actAlloc, 0, 0, 0, 0, errOutOfMemory);
    addRow(actFree, 2, 0, 0, 0, errNone);
    addRow(actFree, 1, 0, 0, 0, errNone);
    addRow(actAlloc, 0, 0, 0, 1, errNone);                // Last freed comes back first
    addRow(actAlloc, 0, 0, 0, 2, errNone);
    addRow(actClear, 0, 0, 0, 0, errNone);
    addRow(actRead, 1, 0, 0, 0, errNotAllocated);
    addRow(actAlloc, 0, 0, 0, 0, errNone);
    addRow(actWrite, 0, 2, 12'h5a3, 12'h5a3, errNone);
    addRow(actSize, 0, 0, 0, 3, errNone);
    addRow(actRead, 0, 2, 0, 12'h5a3, errNone);
    addRow(actRead, 0, 3, 0, 0, errOutOfBounds);
    addRow(actAlloc, 0, 0, 0, 1, errNone);
    for (int i = 1; i <= `HEAP_LENGTH; i++)
      addRow(actPush, 1, 0, 12'h111 * i, 12'h111 * i, errNone);
    addRow(actPush, 1, 0, 12'h555, 0, errFull);
    for (int i = `HEAP_LENGTH; i >= 1; i--)
      addRow(actPop, 1, 0, 0, 12'h111 * i, errNone);
    addRow(actPop, 1, 0, 0, 0, errEmpty);
    addRow(actAdd, 0, 2, 12'hb70, 12'h113, errNone);      // Sum wraps at data width
    addRow(actRead, 0, 2, 0, 12'h113, errNone);
    addRow(actAdd, 0, 3, 12'h001, 0, errOutOfBounds);
    addRow(actAdd, 3, 0, 12'h001, 0, errNotAllocated);
    directedCount = rows.size();

    // Random words into array 2 and count checks against the model
    for (int round = 0; round < 3; round++) begin
      model.delete();
      addRow(actAlloc, 0, 0, 0, 2, errNone);
      for (int n = 0; n < round + 2; n++) begin
        randomValue = $random(seed);
        word        = randomValue[`HEAP_DATA_BITS-1:0];
        model.push_back(word);
        addRow(actPush, 2, 0, word, word, errNone);
      end
      randomValue = $random(seed);
      word        = randomValue[`HEAP_DATA_BITS-1:0];
      addRow(actLess, 2, 0, word, countModel(word, 1'b1), errNone);
      addRow(actGreater, 2, 0, word, countModel(word, 1'b0), errNone);
      addRow(actFree, 2, 0, 0, 0, errNone);
    end
    randomCount = rows.size() - directedCount;
  endtask

  // ------------------------------------------------------------
  // Response monitor
  // ------------------------------------------------------------
  always @(negedge clock) begin
    negCount++;
    if (done) begin
      if (pending.size() == 0)
        reportFailure("A done pulse arrived with no command pending");
      else begin
        checkValue("done cycle", negCount, pending[0].doneCycle);
        checkValue("dataOut", dataOut, pending[0].data);
        checkValue("error", error, pending[0].error);
        void'(pending.pop_front());
      end
    end else if (pending.size() != 0 && pending[0].doneCycle <= negCount)
      reportFailure("A command got no done pulse three cycles after its start");
  end

  initial begin
    wait (tableReady);
    #((directedCount + randomCount + 20) * ClockPeriod);
    reportFailure("Timeout, the run did not finish in time");
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    resetN = 1'b0;
    start  = 1'b0;
    action = actClear;
    array  = '0;
    index  = '0;
    dataIn = '0;
    seed   = 32'hd45a_0786;
    buildTable();
    tableReady = 1'b1;

    repeat (4) @(posedge clock);
    resetN <= 1'b1;
    @(negedge clock);
    checkValue("done", done, 0);
    checkValue("error", error, errNone);
    checkValue("dataOut", dataOut, 0);

    foreach (rows[i]) begin
      @(posedge clock);
      start  <= 1'b1;
      action <= rows[i].action;
      array  <= rows[i].array;
      index  <= rows[i].index;
      dataIn <= rows[i].data;
      pending.push_back('{rows[i].expData, rows[i].expError, negCount + Latency});
    end
    @(posedge clock);
    start <= 1'b0;

    while (pending.size() != 0)
      @(negedge clock);
    repeat (3) @(negedge clock);                          // Catch stray done pulses

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/heapMemory.sv
// Array heap top level
// Fixed-size arrays with per-array size, three-cycle command latency

`timescale 1ns/1ps
`default_nettype none

`include "heap_defs.svh"

module heapMemory (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        start,
  input  heapPkg::heapAction_t        action,
  input  logic [`HEAP_ARRAY_BITS-1:0] array,
  input  logic [`HEAP_INDEX_BITS-1:0] index,
  input  logic [`HEAP_DATA_BITS-1:0]  dataIn,
  output logic                        done,
  output logic [`HEAP_DATA_BITS-1:0]  dataOut,
  output heapPkg::heapError_t         error
);
  import heapPkg::*;

  heapBusIf    bus ();
  bankResult_t bankResults [`HEAP_ARRAYS];               // One entry per bank

  heapAllocator allocator_i (
    .clock  (clock),
    .resetN (resetN),
    .start  (start),
    .action (action),
    .array  (array),
    .index  (index),
    .data   (dataIn),
    .bus    (bus)
  );

  for (genvar i = 0; i < `HEAP_ARRAYS; i++) begin : gBank
    arrayBank #(.bankId(i)) bank_i (
      .clock  (clock),
      .resetN (resetN),
      .bus    (bus),
      .result (bankResults[i])
    );
  end

  resultSelect merge_i (
    .clock   (clock),
    .resetN  (resetN),
    .bus     (bus),
    .results (bankResults),
    .done    (done),
    .dataOut (dataOut),
    .error   (error)
  );

endmodule

`default_nettype wire

// File: rtl/resultSelect.sv
// Result merge
// Lines the allocator verdict up with the bank results and
// registers the final response

`timescale 1ns/1ps
`default_nettype none

`include "heap_defs.svh"

module resultSelect (
  input  logic                        clock,
  input  logic                        resetN,
  heapBusIf.merge                     bus,
  input  heapPkg::bankResult_t        results [`HEAP_ARRAYS],
  output logic                        done,
  output logic [`HEAP_DATA_BITS-1:0]  dataOut,
  output heapPkg::heapError_t         error
);
  import heapPkg::*;

  localparam int DataBits = `HEAP_DATA_BITS;

  logic                        validQ;
  heapError_t                  statusQ;                   // Allocator verdict, one cycle late
  logic [`HEAP_ARRAY_BITS-1:0] allocDataQ;

  logic [`HEAP_ARRAYS-1:0]     hits;
  logic [`HEAP_DATA_BITS-1:0]  hitData;
  heapError_t                  hitError;
  heapError_t                  errorNext;
  logic [`HEAP_DATA_BITS-1:0]  dataNext;

  always_comb begin
    hitData  = '0;
    hitError = errNone;
    for (int i = 0; i < `HEAP_ARRAYS; i++) begin
      hits[i] = results[i].hit;
      if (results[i].hit) begin
        hitData  = results[i].data;
        hitError = results[i].error;
      end
    end
  end

  // Allocator errors win; alloc data is zero except on alloc
  assign errorNext = (statusQ != errNone) ? statusQ : hitError;
  assign dataNext  = (errorNext != errNone) ? '0 : (hitData | DataBits'(allocDataQ));

  always_ff @(posedge clock) begin
    statusQ    <= bus.allocStatus;
    allocDataQ <= bus.allocData;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      validQ  <= 1'b0;
      done    <= 1'b0;
      dataOut <= '0;
      error   <= errNone;
    end else begin
      validQ  <= bus.valid;
      done    <= validQ;
      dataOut <= validQ ? dataNext : '0;
      error   <= validQ ? errorNext : errNone;
    end
  end

  // A hit only answers a command the allocator passed on
  assert property (@(posedge clock) disable iff (!resetN)
    $onehot0(hits) && (validQ || hits == '0));

endmodule

`default_nettype wire

// File: rtl/arrayBank.sv
// Array bank
// Storage and size of one heap array, running the element operations
// with bounds checks and returning one registered result per command

`timescale 1ns/1ps
`default_nettype none

`include "heap_defs.svh"

module arrayBank #(
  parameter int bankId = 0
) (
  input  logic                 clock,
  input  logic                 resetN,
  heapBusIf.bank               bus,
  output heapPkg::bankResult_t result
);
  import heapPkg::*;

  localparam int DataBits = `HEAP_DATA_BITS;

  logic [`HEAP_DATA_BITS-1:0]  elements [`HEAP_LENGTH];
  logic [`HEAP_INDEX_BITS:0]   size;                      // Elements in use
  logic [`HEAP_INDEX_BITS:0]   sizeNext;

  logic                        selected;
  logic                        inRange;                   // Index below size
  logic [`HEAP_DATA_BITS-1:0]  element;
  logic [`HEAP_DATA_BITS-1:0]  sum;
  logic [`HEAP_INDEX_BITS-1:0] topIndex;
  logic [`HEAP_INDEX_BITS:0]   lessCount;
  logic [`HEAP_INDEX_BITS:0]   greaterCount;

  logic                        writeEnable;
  logic [`HEAP_INDEX_BITS-1:0] writeIndex;
  logic [`HEAP_DATA_BITS-1:0]  writeData;
  bankResult_t                 resultNext;

  assign selected = bus.valid && bus.bankSelect[bankId];
  assign inRange  = {1'b0, bus.index} < size;
  assign element  = elements[bus.index];
  assign sum      = element + bus.data;                   // Wraps at data width
  assign topIndex = size[`HEAP_INDEX_BITS-1:0] - 1'b1;

  // Compare counts over the live part of the array
  always_comb begin
    lessCount    = '0;
    greaterCount = '0;
    for (int i = 0; i < `HEAP_LENGTH; i++) begin
      if (i < size && elements[i] < bus.data)
        lessCount = lessCount + 1'b1;
      if (i < size && elements[i] > bus.data)
        greaterCount = greaterCount + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Operation decode
  // ------------------------------------------------------------
  always_comb begin
    writeEnable = 1'b0;
    writeIndex  = bus.index;
    writeData   = bus.data;
    sizeNext    = size;
    resultNext  = '{hit: 1'b0, data: '0, error: errNone};
    if (selected) begin
      resultNext.hit = 1'b1;
      case (bus.action)
        actAlloc, actFree:
          sizeNext = '0;                                  // Fresh or released array
        actWrite: begin                                   // Any index fits the capacity
          writeEnable     = 1'b1;
          resultNext.data = bus.data;
          if (!inRange)
            sizeNext = {1'b0, bus.index} + 1'b1;
        end
        actRead: begin
          if (inRange)
            resultNext.data = element;
          else
            resultNext.error = errOutOfBounds;
        end
        actSize:
          resultNext.data = DataBits'(size);
        actPush: begin
          if (size < `HEAP_LENGTH) begin
            writeEnable     = 1'b1;
            writeIndex      = size[`HEAP_INDEX_BITS-1:0];
            sizeNext        = size + 1'b1;
            resultNext.data = bus.data;
          end else
            resultNext.error = errFull;
        end
        actPop: begin
          if (size != '0) begin
            sizeNext        = size - 1'b1;
            resultNext.data = elements[topIndex];
          end else
            resultNext.error = errEmpty;
        end
        actLess:
          resultNext.data = DataBits'(lessCount);
        actGreater:
          resultNext.data = DataBits'(greaterCount);
        actAdd: begin
          if (inRange) begin
            writeEnable     = 1'b1;
            writeData       = sum;
            resultNext.data = sum;
          end else
            resultNext.error = errOutOfBounds;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (writeEnable)
      elements[writeIndex] <= writeData;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      size   <= '0;
      result <= '{hit: 1'b0, data: '0, error: errNone};
    end else begin
      size   <= sizeNext;
      result <= resultNext;
    end
  end

  assert property (@(posedge clock) disable iff (!resetN) size <= `HEAP_LENGTH);

endmodule

`default_nettype wire

// File: rtl/heapAllocator.sv
// Heap allocator
// Samples commands, tracks allocated arrays and the free stack,
// checks ownership and selects the bank that runs the command

`timescale 1ns/1ps
`default_nettype none

`include "heap_defs.svh"

module heapAllocator (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        start,
  input  heapPkg::heapAction_t        action,
  input  logic [`HEAP_ARRAY_BITS-1:0] array,
  input  logic [`HEAP_INDEX_BITS-1:0] index,
  input  logic [`HEAP_DATA_BITS-1:0]  data,
  heapBusIf.allocator                 bus
);
  import heapPkg::*;

  logic                        startQ;
  heapAction_t                 actionQ;
  logic [`HEAP_ARRAY_BITS-1:0] arrayQ;
  logic [`HEAP_INDEX_BITS-1:0] indexQ;
  logic [`HEAP_DATA_BITS-1:0]  dataQ;

  logic [`HEAP_ARRAYS-1:0]     allocated;                  // One flag per array
  logic [`HEAP_ARRAY_BITS-1:0] freeStack [`HEAP_ARRAYS];   // Freed arrays, last in first out
  logic [`HEAP_ARRAY_BITS:0]   freeDepth;
  logic [`HEAP_ARRAY_BITS:0]   usedCount;                  // Arrays handed out at least once
  logic [`HEAP_ARRAY_BITS-1:0] stackTop;

  logic                        fromStack;
  logic                        canAlloc;
  logic [`HEAP_ARRAY_BITS-1:0] allocPick;
  logic [`HEAP_ARRAYS-1:0]     selectNext;
  heapError_t                  statusNext;
  logic [`HEAP_ARRAY_BITS-1:0] allocDataNext;

  // ------------------------------------------------------------
  // Input sampling
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      startQ <= 1'b0;
    else
      startQ <= start;
  end

  always_ff @(posedge clock) begin
    actionQ <= action;
    arrayQ  <= array;
    indexQ  <= index;
    dataQ   <= data;
  end

  // ------------------------------------------------------------
  // Decision
  // ------------------------------------------------------------
  assign stackTop  = freeDepth[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign fromStack = freeDepth != '0;
  assign canAlloc  = fromStack || usedCount < `HEAP_ARRAYS;
  assign allocPick = fromStack ? freeStack[stackTop] : usedCount[`HEAP_ARRAY_BITS-1:0];

  always_comb begin
    selectNext    = '0;
    statusNext    = errNone;
    allocDataNext = '0;
    if (startQ) begin
      case (actionQ)
        actClear: ;                                        // No bank involved
        actAlloc: begin
          if (canAlloc) begin
            selectNext[allocPick] = 1'b1;                  // Bank clears its size
            allocDataNext         = allocPick;
          end else
            statusNext = errOutOfMemory;
        end
        default: begin
          if (allocated[arrayQ])
            selectNext[arrayQ] = 1'b1;
          else
            statusNext = errNotAllocated;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // Allocation state and bus drive
  // ------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated      <= '0;
      freeDepth      <= '0;
      usedCount      <= '0;
      bus.valid      <= 1'b0;
      bus.bankSelect <= '0;
    end else begin
      bus.valid      <= startQ;
      bus.bankSelect <= selectNext;
      if (startQ) begin
        case (actionQ)
          actClear: begin
            allocated <= '0;
            freeDepth <= '0;
            usedCount <= '0;
          end
          actAlloc: begin
            if (canAlloc) begin
              allocated[allocPick] <= 1'b1;
              if (fromStack)
                freeDepth <= freeDepth - 1'b1;
              else
                usedCount <= usedCount + 1'b1;
            end
          end
          actFree: begin
            if (allocated[arrayQ]) begin
              allocated[arrayQ] <= 1'b0;
              freeDepth         <= freeDepth + 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (startQ && actionQ == actFree && allocated[arrayQ])
      freeStack[freeDepth[`HEAP_ARRAY_BITS-1:0]] <= arrayQ;
    bus.action      <= actionQ;
    bus.index       <= indexQ;
    bus.data        <= dataQ;
    bus.allocStatus <= statusNext;
    bus.allocData   <= allocDataNext;
  end

  // A bank is only ever picked alongside a valid command
  assert property (@(posedge clock) disable iff (!resetN)
    $onehot0(bus.bankSelect) && (bus.valid || bus.bankSelect == '0));

endmodule

`default_nettype wire

// File: rtl/heapBusIf.sv
// Heap command bus
// Carries a decoded command from the allocator to the banks and the merge stage

`timescale 1ns/1ps
`default_nettype none

`include "heap_defs.svh"

interface heapBusIf;
  import heapPkg::*;

  logic                        valid;        // One cycle per accepted command
  logic [`HEAP_ARRAYS-1:0]     bankSelect;   // One-hot or zero
  heapAction_t                 action;
  logic [`HEAP_INDEX_BITS-1:0] index;
  logic [`HEAP_DATA_BITS-1:0]  data;
  heapError_t                  allocStatus;  // Allocator verdict
  logic [`HEAP_ARRAY_BITS-1:0] allocData;    // Array number from alloc, zero otherwise

  modport allocator (
    output valid, bankSelect, action, index, data, allocStatus, allocData
  );

  modport bank (
    input valid, bankSelect, action, index, data
  );

  modport merge (
    input valid, allocStatus, allocData
  );

endinterface

`default_nettype wire

// File: rtl/heapPkg.sv
// Heap types
// Command actions, error codes and the per-bank result record

`default_nettype none

`include "heap_defs.svh"

package heapPkg;

  typedef enum logic [3:0] {
    actClear   = 4'd0,                      // Free every array
    actAlloc   = 4'd1,
    actFree    = 4'd2,
    actWrite   = 4'd3,                      // Grows size to cover index
    actRead    = 4'd4,
    actSize    = 4'd5,
    actPush    = 4'd6,
    actPop     = 4'd7,
    actLess    = 4'd8,                      // Count below data word
    actGreater = 4'd9,                      // Count above data word
    actAdd     = 4'd10                      // Returns new value
  } heapAction_t;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,
    errOutOfBounds  = 3'd2,
    errFull         = 3'd3,
    errEmpty        = 3'd4,
    errOutOfMemory  = 3'd5
  } heapError_t;

  typedef struct packed {
    logic                       hit;        // Bank acted on a command
    logic [`HEAP_DATA_BITS-1:0] data;
    heapError_t                 error;
  } bankResult_t;

endpackage

`default_nettype wire

// File: include/heap_defs.svh
// Heap sizing
// Widths and counts shared by the array heap and its testbench

`ifndef HEAP_DEFS_SVH
`define HEAP_DEFS_SVH

// ------------------------------------------------------------
// Array numbering and capacity
// ------------------------------------------------------------
`define HEAP_ARRAY_BITS 2                   // Bits in an array number
`define HEAP_ARRAYS     4                   // Arrays in the heap
`define HEAP_INDEX_BITS 2                   // Bits in an element index
`define HEAP_LENGTH     4                   // Elements per array, size needs one more bit

`define HEAP_DATA_BITS  12                  // Data word width

`endif
